// File: compile.f
+incdir+sim
rtl/shell_pkg.sv
rtl/rf_if.sv
rtl/sleep_ctrl.sv
rtl/register_file.sv
rtl/scramble_key_ctrl.sv
rtl/core_shell_top.sv
sim/tb_core_shell.sv

// File: rtl/core_shell_top.sv
// Support shell around a RISC-V core, core itself is outside
// Register file runs on the gated clock, key logic on the free clock
// Scrambling key goes out as ports for an external RAM

`timescale 1ns/1ps
`default_nettype none

module core_shell_top (
  input  logic                          clk_i,
  input  logic                          rst_ni,

  // Sleep control
  input  logic                          core_busy_i,
  input  logic                          debug_req_i,
  input  logic [shell_pkg::NumIrqs-1:0] irq_i,
  input  logic                          irq_nm_i,
  output logic                          core_sleep_o,

  // Key handshake
  input  logic                          icache_inval_i,
  input  logic                          scramble_key_valid_i,
  input  shell_pkg::scr_key_t           scramble_key_i,
  input  shell_pkg::scr_nonce_t         scramble_nonce_i,
  output logic                          scramble_req_o,
  output logic                          scr_key_valid_o,
  output shell_pkg::scr_key_t           scr_key_o,
  output shell_pkg::scr_nonce_t         scr_nonce_o,

  // Register file, core side
  input  shell_pkg::reg_addr_t          rf_raddr_a_i,
  input  shell_pkg::reg_addr_t          rf_raddr_b_i,
  input  shell_pkg::reg_addr_t          rf_waddr_i,
  input  shell_pkg::reg_data_t          rf_wdata_i,
  input  logic                          rf_we_i,
  output shell_pkg::reg_data_t          rf_rdata_a_o,
  output shell_pkg::reg_data_t          rf_rdata_b_o
);

  logic clk_gated;

  rf_if rf_bus ();

  //////////////////////////////////////////////////////////////////////
  // Main clock gate
  //////////////////////////////////////////////////////////////////////

  sleep_ctrl u_sleep_ctrl (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .core_busy_i (core_busy_i),
    .debug_req_i (debug_req_i),
    .irq_i       (irq_i),
    .irq_nm_i    (irq_nm_i),
    .core_sleep_o(core_sleep_o),
    .clk_gated_o (clk_gated)
  );

  //////////////////////////////////////////////////////////////////////
  // Register file
  //////////////////////////////////////////////////////////////////////

  assign rf_bus.raddr_a = rf_raddr_a_i;
  assign rf_bus.raddr_b = rf_raddr_b_i;
  assign rf_bus.waddr   = rf_waddr_i;
  assign rf_bus.wdata   = rf_wdata_i;
  assign rf_bus.we      = rf_we_i;
  assign rf_rdata_a_o   = rf_bus.rdata_a;
  assign rf_rdata_b_o   = rf_bus.rdata_b;

  register_file u_register_file (
    .clk_i (clk_gated),
    .rst_ni(rst_ni),
    .rf    (rf_bus.rf)
  );

  //////////////////////////////////////////////////////////////////////
  // Scrambling key
  //////////////////////////////////////////////////////////////////////

  scramble_key_ctrl u_scramble_key_ctrl (
    .clk_i               (clk_i),
    .rst_ni              (rst_ni),
    .icache_inval_i      (icache_inval_i),
    .scramble_key_valid_i(scramble_key_valid_i),
    .scramble_key_i      (scramble_key_i),
    .scramble_nonce_i    (scramble_nonce_i),
    .scramble_req_o      (scramble_req_o),
    .scr_key_valid_o     (scr_key_valid_o),
    .scr_key_o           (scr_key_o),
    .scr_nonce_o         (scr_nonce_o)
  );

endmodule

`default_nettype wire

// File: rtl/register_file.sv
// Flip-flop register file, 31 writable entries plus a hard-wired zero
// Clocked by the gated core clock, so writes are lost while asleep
// Entry zero reads as zero whatever is written to it

`timescale 1ns/1ps
`default_nettype none

module register_file (
  input  logic clk_i,
  input  logic rst_ni,
  rf_if.rf     rf
);

  shell_pkg::reg_data_t            rf_q [shell_pkg::NumRegs];
  logic [shell_pkg::NumRegs-1:1]   we_dec;

  //////////////////////////////////////////////////////////////////////
  // Write decode
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    for (int unsigned i = 1; i < shell_pkg::NumRegs; i++) begin
      we_dec[i] = rf.we && (rf.waddr == shell_pkg::reg_addr_t'(i));
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Storage
  //////////////////////////////////////////////////////////////////////

  // Entry zero has no flops
  assign rf_q[0] = '0;

  for (genvar i = 1; i < shell_pkg::NumRegs; i++) begin : gen_regs
    always_ff @(posedge clk_i or negedge rst_ni) begin
      if (!rst_ni) begin
        rf_q[i] <= '0;
      end else if (we_dec[i]) begin
        rf_q[i] <= rf.wdata;
      end
    end
  end

  // Read ports
  assign rf.rdata_a = rf_q[rf.raddr_a];
  assign rf.rdata_b = rf_q[rf.raddr_b];

  // Unknown write address would corrupt an arbitrary entry
  a_waddr_known: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    rf.we |-> !$isunknown(rf.waddr)
  ) else $error("register file write with unknown address");

endmodule

`default_nettype wire

// File: rtl/rf_if.sv
// Register file access bundle, two read ports and one write port
// Reads are combinational, writes land on the register file clock

`timescale 1ns/1ps
`default_nettype none

interface rf_if;

  shell_pkg::reg_addr_t raddr_a;
  shell_pkg::reg_addr_t raddr_b;
  shell_pkg::reg_data_t rdata_a;
  shell_pkg::reg_data_t rdata_b;
  shell_pkg::reg_addr_t waddr;
  shell_pkg::reg_data_t wdata;
  logic                 we;

  // Core side
  modport core (
    output raddr_a, raddr_b, waddr, wdata, we,
    input  rdata_a, rdata_b
  );

  // Storage side
  modport rf (
    input  raddr_a, raddr_b, waddr, wdata, we,
    output rdata_a, rdata_b
  );

endinterface

`default_nettype wire

// File: rtl/scramble_key_ctrl.sv
// Scrambling key and nonce holder with key request handshake
// Key source may answer after any delay, request held until it does
// Any valid pulse loads a new key, requested or not

`timescale 1ns/1ps
`default_nettype none

module scramble_key_ctrl (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  logic                  icache_inval_i,
  input  logic                  scramble_key_valid_i,
  input  shell_pkg::scr_key_t   scramble_key_i,
  input  shell_pkg::scr_nonce_t scramble_nonce_i,
  output logic                  scramble_req_o,
  output logic                  scr_key_valid_o,
  output shell_pkg::scr_key_t   scr_key_o,
  output shell_pkg::scr_nonce_t scr_nonce_o
);

  shell_pkg::key_req_state_e state_d, state_q;
  logic                      key_valid_d, key_valid_q;
  shell_pkg::scr_key_t       key_q;
  shell_pkg::scr_nonce_t     nonce_q;

  //////////////////////////////////////////////////////////////////////
  // Request FSM
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    state_d     = state_q;
    key_valid_d = key_valid_q;
    case (state_q)
      shell_pkg::KEY_IDLE: begin
        // Invalidate drops the key and asks for a fresh one
        if (icache_inval_i) begin
          state_d     = shell_pkg::KEY_REQ;
          key_valid_d = 1'b0;
        end
      end
      shell_pkg::KEY_REQ: begin
        key_valid_d = scramble_key_valid_i;
        if (scramble_key_valid_i) begin
          state_d = shell_pkg::KEY_IDLE;
        end
      end
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q     <= shell_pkg::KEY_IDLE;
      key_valid_q <= 1'b1;
    end else begin
      state_q     <= state_d;
      key_valid_q <= key_valid_d;
    end
  end

  // Key and nonce
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      key_q   <= shell_pkg::KeyDefault;
      nonce_q <= shell_pkg::NonceDefault;
    end else if (scramble_key_valid_i) begin
      key_q   <= scramble_key_i;
      nonce_q <= scramble_nonce_i;
    end
  end

  assign scramble_req_o  = (state_q == shell_pkg::KEY_REQ);
  assign scr_key_valid_o = key_valid_q;
  assign scr_key_o       = key_q;
  assign scr_nonce_o     = nonce_q;

  // A pending request means the current key is stale
  a_req_excl_valid: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    !(scramble_req_o && scr_key_valid_o)
  ) else $error("key request raised while key is valid");

  a_req_known: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    !$isunknown(scramble_req_o)
  ) else $error("scramble_req_o is unknown");

endmodule

`default_nettype wire

// File: rtl/shell_pkg.sv
// Shared widths, types and reset constants for the core support shell
// Register file geometry is fixed at 32 x 32 bits, no RV32E variant

`default_nettype none

package shell_pkg;

  //////////////////////////////////////////////////////////////////////
  // Widths
  //////////////////////////////////////////////////////////////////////

  localparam int unsigned RegAddrW  = 5;
  localparam int unsigned RegDataW  = 32;
  localparam int unsigned NumRegs   = 2 ** RegAddrW;
  localparam int unsigned NumIrqs   = 3;
  localparam int unsigned ScrKeyW   = 128;
  localparam int unsigned ScrNonceW = 64;

  typedef logic [RegAddrW-1:0]  reg_addr_t;
  typedef logic [RegDataW-1:0]  reg_data_t;
  typedef logic [ScrKeyW-1:0]   scr_key_t;
  typedef logic [ScrNonceW-1:0] scr_nonce_t;

  //////////////////////////////////////////////////////////////////////
  // Scrambling defaults
  //////////////////////////////////////////////////////////////////////

  // Used until the key source delivers a first key
  localparam scr_key_t   KeyDefault   = 128'h3b2f_91c4_a7d0_5e68_c15a_02f7_8e43_d9b6;
  localparam scr_nonce_t NonceDefault = 64'h6d1e_f308_47ac_b259;

  // Key request FSM
  typedef enum logic {
    KEY_IDLE = 1'b0,
    KEY_REQ  = 1'b1
  } key_req_state_e;

endpackage

`default_nettype wire

// File: rtl/sleep_ctrl.sv
// Core sleep control and main clock gate
// The busy flag is registered, wake requests act without delay
// No test-mode override on the gate

`timescale 1ns/1ps
`default_nettype none

module sleep_ctrl (
  input  logic                           clk_i,
  input  logic                           rst_ni,
  input  logic                           core_busy_i,
  input  logic                           debug_req_i,
  input  logic [shell_pkg::NumIrqs-1:0]  irq_i,
  input  logic                           irq_nm_i,
  output logic                           core_sleep_o,
  output logic                           clk_gated_o
);

  logic busy_q;
  logic clock_en;
  logic en_latch;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      busy_q <= 1'b0;
    end else begin
      busy_q <= core_busy_i;
    end
  end

  // Any wake source keeps the clock running
  assign clock_en     = busy_q | debug_req_i | (|irq_i) | irq_nm_i;
  assign core_sleep_o = ~clock_en;

  //////////////////////////////////////////////////////////////////////
  // Clock gate
  //////////////////////////////////////////////////////////////////////

  // Latch open while clk_i is low, enable frozen during the high phase
  always_latch begin
    if (!clk_i) begin
      en_latch <= clock_en;
    end
  end

  assign clk_gated_o = clk_i & en_latch;

  // Sleep output steers system power control
  a_sleep_known: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    !$isunknown(core_sleep_o)
  ) else $error("core_sleep_o is unknown");

endmodule

`default_nettype wire

// File: run.sh
#!/bin/sh
# Build and run the testbench with Verilator, result taken from the log
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module tb_core_shell \
  -f compile.f -o sim_tb
./obj_dir/sim_tb > sim.log
cat sim.log
grep -q "^Done: no errors$" sim.log

// File: sim/shell_model.svh
// Reference model of register file, clock gating and key handshake
// Steps once per rising clk_i edge from the inputs applied before it
// Must be included inside the testbench module after its signals

`ifndef SHELL_MODEL_SVH
`define SHELL_MODEL_SVH

shell_pkg::reg_data_t      m_regs [shell_pkg::NumRegs];
logic                      m_busy;
shell_pkg::key_req_state_e m_state;
logic                      m_key_valid;
shell_pkg::scr_key_t       m_key;
shell_pkg::scr_nonce_t     m_nonce;

function automatic void model_reset();
  foreach (m_regs[i]) begin
    m_regs[i] = '0;
  end
  m_busy      = 1'b0;
  m_state     = shell_pkg::KEY_IDLE;
  m_key_valid = 1'b1;
  m_key       = shell_pkg::KeyDefault;
  m_nonce     = shell_pkg::NonceDefault;
endfunction

// Clock runs while busy or any wake source is up
function automatic logic model_clock_en();
  return m_busy | debug_req | (|irq) | irq_nm;
endfunction

function automatic void model_step();
  if (model_clock_en() && rf_we && rf_waddr != '0) begin
    m_regs[rf_waddr] = rf_wdata;
  end
  m_busy = core_busy;
  if (key_valid_in) begin
    m_key   = key_in;
    m_nonce = nonce_in;
  end
  if (m_state == shell_pkg::KEY_IDLE) begin
    if (icache_inval) begin
      m_state     = shell_pkg::KEY_REQ;
      m_key_valid = 1'b0;
    end
  end else begin
    m_key_valid = key_valid_in;
    if (key_valid_in) begin
      m_state = shell_pkg::KEY_IDLE;
    end
  end
endfunction

`endif

// File: sim/tb_core_shell.sv
// Random testbench for the core support shell, fixed seed
// Inputs change on the falling edge, outputs checked just before

`timescale 1ns/1ps
`default_nettype none

module tb_core_shell;

  // Reset, five tests, then margin
  localparam int TestCycles = 4 + 1 + 300 + 300 + 200 + 44;
  localparam int Limit      = TestCycles + 100;

  logic clk_i;
  logic rst_ni;
  logic core_busy, debug_req, irq_nm, core_sleep;
  logic [shell_pkg::NumIrqs-1:0] irq;
  logic icache_inval, key_valid_in, scramble_req, key_valid_out;
  shell_pkg::scr_key_t   key_in, key_out;
  shell_pkg::scr_nonce_t nonce_in, nonce_out;
  shell_pkg::reg_addr_t  raddr_a, raddr_b, rf_waddr;
  shell_pkg::reg_data_t  rf_wdata, rdata_a, rdata_b;
  logic rf_we;

  int checks;
  int errors;
  int cycles;

  `include "shell_model.svh"

  core_shell_top uut (
    .clk_i               (clk_i),
    .rst_ni              (rst_ni),
    .core_busy_i         (core_busy),
    .debug_req_i         (debug_req),
    .irq_i               (irq),
    .irq_nm_i            (irq_nm),
    .core_sleep_o        (core_sleep),
    .icache_inval_i      (icache_inval),
    .scramble_key_valid_i(key_valid_in),
    .scramble_key_i      (key_in),
    .scramble_nonce_i    (nonce_in),
    .scramble_req_o      (scramble_req),
    .scr_key_valid_o     (key_valid_out),
    .scr_key_o           (key_out),
    .scr_nonce_o         (nonce_out),
    .rf_raddr_a_i        (raddr_a),
    .rf_raddr_b_i        (raddr_b),
    .rf_waddr_i          (rf_waddr),
    .rf_wdata_i          (rf_wdata),
    .rf_we_i             (rf_we),
    .rf_rdata_a_o        (rdata_a),
    .rf_rdata_b_o        (rdata_b)
  );

  initial begin
    clk_i = 1'b0;
    forever #2 clk_i = ~clk_i;
  end

  always @(posedge clk_i) begin
    cycles++;
    if (cycles > Limit) begin
      $display("Timeout: run went past %0d cycles", Limit);
      $display("Done: errors found");
      $finish;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Helpers
  //////////////////////////////////////////////////////////////////////

  task automatic compare(input string name, input logic [127:0] got,
                         input logic [127:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("FAILED %s: got %0h, expected %0h", name, got, exp);
    end
  endtask

  // Wait for the falling edge, then check every output against the model
  task automatic step_cycle();
    @(negedge clk_i);
    compare("core_sleep_o", 128'(core_sleep), 128'(!model_clock_en()));
    compare("rf_rdata_a_o", 128'(rdata_a), 128'(m_regs[raddr_a]));
    compare("rf_rdata_b_o", 128'(rdata_b), 128'(m_regs[raddr_b]));
    compare("scramble_req_o", 128'(scramble_req), 128'(m_state == shell_pkg::KEY_REQ));
    compare("scr_key_valid_o", 128'(key_valid_out), 128'(m_key_valid));
    compare("scr_key_o", key_out, m_key);
    compare("scr_nonce_o", 128'(nonce_out), 128'(m_nonce));
  endtask

  task automatic random_rf_access();
    // Bias reads towards entry zero now and then
    raddr_a  = ($urandom % 8 == 0) ? '0 : 5'($urandom);
    raddr_b  = ($urandom % 8 == 0) ? '0 : 5'($urandom);
    rf_waddr = 5'($urandom);
    rf_wdata = $urandom;
    rf_we    = ($urandom % 2 == 0);
  endtask

  task automatic random_key();
    key_in   = {$urandom, $urandom, $urandom, $urandom};
    nonce_in = {$urandom, $urandom};
  endtask

  task automatic report_test(input string name, input int err_before);
    $display("Test %s: %0d errors", name, errors - err_before);
  endtask

  //////////////////////////////////////////////////////////////////////
  // Tests
  //////////////////////////////////////////////////////////////////////

  task automatic test_key_wait();
    int wait_len;
    wait_len = 5 + ($urandom % 36);
    // A valid pulse first guarantees the FSM is idle
    step_cycle();
    key_valid_in = 1'b1;
    icache_inval = 1'b0;
    random_key();
    model_step();
    step_cycle();
    key_valid_in = 1'b0;
    icache_inval = 1'b1;
    model_step();
    for (int i = 0; i < wait_len; i++) begin
      step_cycle();
      compare("scramble_req_o", 128'(scramble_req), 128'(1'b1));
      compare("scr_key_valid_o", 128'(key_valid_out), 128'(1'b0));
      icache_inval = 1'b0;
      model_step();
    end
    step_cycle();
    key_valid_in = 1'b1;
    random_key();
    model_step();
    step_cycle();
    compare("scramble_req_o", 128'(scramble_req), 128'(1'b0));
    compare("scr_key_valid_o", 128'(key_valid_out), 128'(1'b1));
    key_valid_in = 1'b0;
    model_step();
  endtask

  initial begin
    int err_before;
    void'($urandom(32'haca8_1b82));
    checks = 0;
    errors = 0;
    cycles = 0;
    rst_ni = 1'b0;
    {core_busy, debug_req, irq, irq_nm} = '0;
    {icache_inval, key_valid_in, rf_we} = '0;
    key_in   = '0;
    nonce_in = '0;
    {raddr_a, raddr_b, rf_waddr} = '0;
    rf_wdata = '0;
    model_reset();
    repeat (3) @(negedge clk_i);
    rst_ni = 1'b1;
    model_step();

    err_before = errors;
    step_cycle();
    compare("core_sleep_o", 128'(core_sleep), 128'(1'b1));
    compare("scramble_req_o", 128'(scramble_req), 128'(1'b0));
    compare("scr_key_valid_o", 128'(key_valid_out), 128'(1'b1));
    compare("scr_key_o", key_out, shell_pkg::KeyDefault);
    compare("scr_nonce_o", 128'(nonce_out), 128'(shell_pkg::NonceDefault));
    model_step();
    report_test("after reset", err_before);

    err_before = errors;
    for (int i = 0; i < 300; i++) begin
      step_cycle();
      core_busy = 1'b1;
      random_rf_access();
      model_step();
    end
    report_test("register file awake", err_before);

    err_before = errors;
    for (int i = 0; i < 300; i++) begin
      step_cycle();
      core_busy = ($urandom % 2 == 0);
      debug_req = ($urandom % 6 == 0);
      irq       = ($urandom % 6 == 0) ? 3'($urandom) : '0;
      irq_nm    = ($urandom % 8 == 0);
      random_rf_access();
      model_step();
    end
    report_test("sleep and gating", err_before);

    err_before = errors;
    for (int i = 0; i < 200; i++) begin
      step_cycle();
      rf_we        = 1'b0;
      icache_inval = ($urandom % 4 == 0);
      key_valid_in = ($urandom % 5 == 0);
      random_key();
      model_step();
    end
    report_test("key handshake", err_before);

    err_before = errors;
    test_key_wait();
    report_test("waiting for a key", err_before);

    $display("Checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

endmodule

`default_nettype wire
